// File: flist.f
+incdir+logic
logic/apb_pkg.sv
logic/apb_register_slice.sv
logic/apb_decoder.sv
logic/apb_scratch_regs.sv
logic/apb_timer.sv
logic/apb_subsystem.sv
tb/apb_subsystem_tb.sv

// File: logic/apb_config.svh
`ifndef APB_CONFIG_SVH
`define APB_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

// Byte address
`define APB_ADDR_WIDTH 16
`define APB_DATA_WIDTH 32
// One strobe bit per data byte
`define APB_STRB_WIDTH (`APB_DATA_WIDTH / 8)

//////////////////////////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////////////////////////

`define SCRATCH_BASE 16'h0000
`define TIMER_BASE 16'h0100
// Bytes per completer region, power of two
`define REGION_SIZE 16'h0100

// Scratch bank depth in 32-bit words
`define SCRATCH_WORDS 8

`endif

// File: logic/apb_decoder.sv
`timescale 1ns/100ps
`include "apb_config.svh"

module apb_decoder import apb_pkg::*; (
	input apb_req_t req,
	output apb_resp_t resp,
	output apb_req_t scratch_req,
	input apb_resp_t scratch_resp,
	output apb_req_t timer_req,
	input apb_resp_t timer_resp
);

	localparam logic [`APB_ADDR_WIDTH-1:0] scratch_base = `SCRATCH_BASE;
	localparam logic [`APB_ADDR_WIDTH-1:0] timer_base = `TIMER_BASE;

	completer_e target;
	logic access;

	assign access = req.psel && req.penable;

	//////////////////////////////////////////////////////////////////////
	// Address match
	//////////////////////////////////////////////////////////////////////

	// Only the bits above the region offset take part
	always_comb begin
		target = COMP_NONE;
		if (req.paddr[`APB_ADDR_WIDTH-1:region_lsb] ==
			scratch_base[`APB_ADDR_WIDTH-1:region_lsb])
			target = COMP_SCRATCH;
		else if (req.paddr[`APB_ADDR_WIDTH-1:region_lsb] ==
			timer_base[`APB_ADDR_WIDTH-1:region_lsb])
			target = COMP_TIMER;
	end

	//////////////////////////////////////////////////////////////////////
	// Request fan-out
	//////////////////////////////////////////////////////////////////////

	// All fields broadcast, psel steered
	always_comb begin
		scratch_req = req;
		scratch_req.psel = req.psel && (target == COMP_SCRATCH);
		timer_req = req;
		timer_req.psel = req.psel && (target == COMP_TIMER);
	end

	//////////////////////////////////////////////////////////////////////
	// Response merge
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (target)
			COMP_SCRATCH: resp = scratch_resp;
			COMP_TIMER: resp = timer_resp;
			default: begin
				// Unmapped, error with no wait state
				resp.pready = access;
				resp.prdata = '0;
				resp.pslverr = access;
			end
		endcase
	end

	// A completer answers only while the decoder selects it
	always_comb begin
		assert final (!(scratch_resp.pready && !scratch_req.psel) &&
			!(timer_resp.pready && !timer_req.psel))
			else $error("completer answered without its psel");
	end

endmodule

// File: logic/apb_pkg.sv
package apb_pkg;

	`include "apb_config.svh"

	// Low address bits that select a byte inside one region
	localparam int region_lsb = $clog2(`REGION_SIZE);

	//////////////////////////////////////////////////////////////////////
	// Bus structs
	//////////////////////////////////////////////////////////////////////

	// Requester to completer
	typedef struct packed {
		logic [`APB_ADDR_WIDTH-1:0] paddr;
		logic psel;
		logic penable;
		logic pwrite;
		logic [`APB_DATA_WIDTH-1:0] pwdata;
		logic [`APB_STRB_WIDTH-1:0] pstrb;
		logic [2:0] pprot;
	} apb_req_t;

	// Completer to requester, data and error valid with pready only
	typedef struct packed {
		logic pready;
		logic [`APB_DATA_WIDTH-1:0] prdata;
		logic pslverr;
	} apb_resp_t;

	// Timer register offsets inside its region
	typedef enum logic [region_lsb-1:0] {
		TIMER_CTRL = 'h0,
		TIMER_COUNT = 'h4,
		TIMER_COMPARE = 'h8,
		TIMER_STATUS = 'hC
	} timer_reg_e;

	// Decoder targets
	typedef enum logic [1:0] {
		COMP_SCRATCH,
		COMP_TIMER,
		COMP_NONE
	} completer_e;

endpackage

// File: logic/apb_register_slice.sv
`timescale 1ns/100ps
`include "apb_config.svh"

module apb_register_slice import apb_pkg::*; #(
	// Register the response path toward the requester
	parameter bit up_reg = 1,
	// Register the request path toward the completers
	parameter bit down_reg = 1
) (
	input logic upstream,
	input logic reset,
	input apb_req_t up_req,
	output apb_resp_t up_resp,
	output apb_req_t down_req,
	input apb_resp_t down_resp
);

	// Set by downstream pready, held until upstream penable drops
	logic done;

	//////////////////////////////////////////////////////////////////////
	// Request path
	//////////////////////////////////////////////////////////////////////

	if (down_reg) begin : g_down_reg

		always_ff @(posedge upstream) begin
			if (reset) begin
				down_req <= '0;
				done <= 1'b0;
			end else begin
				down_req <= up_req;

				// Completer finished, but upstream penable is still high
				// until the delayed pready reaches the requester
				if (down_resp.pready) begin
					done <= 1'b1;
					down_req.penable <= 1'b0;
				end

				// Keep the completer out of a second access phase
				if (done)
					down_req.penable <= 1'b0;

				// End of the upstream transfer
				if (!up_req.penable)
					done <= 1'b0;
			end
		end

	end else begin : g_down_comb

		always_ff @(posedge upstream) begin
			if (reset) begin
				done <= 1'b0;
			end else begin
				if (down_resp.pready)
					done <= 1'b1;
				if (!up_req.penable)
					done <= 1'b0;
			end
		end

		// Straight through, penable blanked while done
		always_comb begin
			down_req = up_req;
			if (done)
				down_req.penable = 1'b0;
		end

	end

	//////////////////////////////////////////////////////////////////////
	// Response path
	//////////////////////////////////////////////////////////////////////

	if (up_reg) begin : g_up_reg

		always_ff @(posedge upstream) begin
			if (reset)
				up_resp <= '0;
			else
				up_resp <= down_resp;
		end

	end else begin : g_up_comb

		assign up_resp = down_resp;

	end

	// No access phase toward a completer that was never selected
	assert property (@(posedge upstream) disable iff (reset)
		$rose(down_req.penable) |-> down_req.psel)
		else $error("down penable rose without psel");

endmodule

// File: logic/apb_scratch_regs.sv
`timescale 1ns/100ps
`include "apb_config.svh"

module apb_scratch_regs import apb_pkg::*; (
	input logic upstream,
	input logic reset,
	input apb_req_t req,
	output apb_resp_t resp
);

	localparam int idx_bits = $clog2(`SCRATCH_WORDS);

	logic [`APB_DATA_WIDTH-1:0] regs [`SCRATCH_WORDS];
	logic [idx_bits-1:0] idx;
	logic access;

	// Word index, upper in-region bits alias
	assign idx = req.paddr[2 +: idx_bits];
	assign access = req.psel && req.penable;

	//////////////////////////////////////////////////////////////////////
	// Byte-strobe writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge upstream) begin
		if (reset) begin
			for (int i = 0; i < `SCRATCH_WORDS; i++)
				regs[i] <= '0;
		end else if (access && req.pwrite) begin
			// Only strobed bytes change
			for (int b = 0; b < `APB_STRB_WIDTH; b++) begin
				if (req.pstrb[b])
					regs[idx][8*b +: 8] <= req.pwdata[8*b +: 8];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Response
	//////////////////////////////////////////////////////////////////////

	// Zero wait states, never an error
	always_comb begin
		resp.pready = access;
		resp.pslverr = 1'b0;
		// Read data only on a read access
		if (access && !req.pwrite)
			resp.prdata = regs[idx];
		else
			resp.prdata = '0;
	end

endmodule

// File: logic/apb_subsystem.sv
`timescale 1ns/100ps

module apb_subsystem import apb_pkg::*; (
	input logic upstream,
	input logic reset,
	input apb_req_t req,
	output apb_resp_t resp,
	output logic timer_irq
);

	// Slice down side to decoder
	apb_req_t slice_req;
	apb_resp_t slice_resp;

	// Decoder to completers
	apb_req_t scratch_req;
	apb_resp_t scratch_resp;
	apb_req_t timer_req;
	apb_resp_t timer_resp;

	//////////////////////////////////////////////////////////////////////
	// Pipeline stage, both directions registered
	//////////////////////////////////////////////////////////////////////

	apb_register_slice #(
		.up_reg(1),
		.down_reg(1)
	) u_slice (
		.upstream(upstream),
		.reset(reset),
		.up_req(req),
		.up_resp(resp),
		.down_req(slice_req),
		.down_resp(slice_resp)
	);

	apb_decoder u_decoder (
		.req(slice_req),
		.resp(slice_resp),
		.scratch_req(scratch_req),
		.scratch_resp(scratch_resp),
		.timer_req(timer_req),
		.timer_resp(timer_resp)
	);

	//////////////////////////////////////////////////////////////////////
	// Completers
	//////////////////////////////////////////////////////////////////////

	apb_scratch_regs u_scratch (
		.upstream(upstream),
		.reset(reset),
		.req(scratch_req),
		.resp(scratch_resp)
	);

	apb_timer u_timer (
		.upstream(upstream),
		.reset(reset),
		.req(timer_req),
		.resp(timer_resp),
		.timer_irq(timer_irq)
	);

endmodule

// File: logic/apb_timer.sv
`timescale 1ns/100ps
`include "apb_config.svh"

module apb_timer import apb_pkg::*; (
	input logic upstream,
	input logic reset,
	input apb_req_t req,
	output apb_resp_t resp,
	output logic timer_irq
);

	logic enable;
	logic [`APB_DATA_WIDTH-1:0] count;
	logic [`APB_DATA_WIDTH-1:0] compare;
	logic status;

	// High in the second access cycle
	logic wait_q;
	logic access;
	logic ack;
	logic hit;
	logic [`APB_DATA_WIDTH-1:0] rdata;
	timer_reg_e offset;

	assign access = req.psel && req.penable;
	assign ack = access && wait_q;
	assign offset = timer_reg_e'(req.paddr[region_lsb-1:0]);

	// Wait state, cleared on the pready cycle
	always_ff @(posedge upstream) begin
		if (reset)
			wait_q <= 1'b0;
		else
			wait_q <= access && !wait_q;
	end

	//////////////////////////////////////////////////////////////////////
	// Register decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		hit = 1'b1;
		rdata = '0;
		case (offset)
			TIMER_CTRL: rdata[0] = enable;
			TIMER_COUNT: rdata = count;
			TIMER_COMPARE: rdata = compare;
			TIMER_STATUS: rdata[0] = status;
			default: hit = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Counter and match
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge upstream) begin
		if (reset) begin
			enable <= 1'b0;
			count <= '0;
			compare <= '0;
			status <= 1'b0;
		end else begin
			// Software load wins over counting
			if (ack && req.pwrite && offset == TIMER_COUNT)
				count <= req.pwdata;
			else if (enable)
				count <= count + 1'b1;

			if (ack && req.pwrite && offset == TIMER_CTRL)
				enable <= req.pwdata[0];
			if (ack && req.pwrite && offset == TIMER_COMPARE)
				compare <= req.pwdata;

			// Write one to clear, a match in the same cycle wins
			if (ack && req.pwrite && offset == TIMER_STATUS && req.pwdata[0])
				status <= 1'b0;
			if (enable && count == compare)
				status <= 1'b1;
		end
	end

	assign timer_irq = status;

	// Unknown offset answers with an error, no data
	assign resp.pready = ack;
	assign resp.pslverr = ack && !hit;
	assign resp.prdata = (ack && !req.pwrite && hit) ? rdata : '0;

	// Request fields held through the wait state up to pready
	assert property (@(posedge upstream) disable iff (reset)
		resp.pready |-> $stable(req.paddr) && $stable(req.pwrite) && $stable(req.pwdata))
		else $error("timer request changed during the wait state");

endmodule

// File: tb/apb_subsystem_tb.sv
`timescale 1ns/100ps
`include "apb_config.svh"

module apb_subsystem_tb import apb_pkg::*; ();

	// One table row, a single APB transfer and its expected response
	typedef struct packed {
		logic write;
		logic [`APB_ADDR_WIDTH-1:0] addr;
		logic [`APB_DATA_WIDTH-1:0] wdata;
		logic [`APB_STRB_WIDTH-1:0] strb;
		logic [`APB_DATA_WIDTH-1:0] exp_rdata;
		logic exp_err;
	} step_t;

	localparam logic [`APB_ADDR_WIDTH-1:0] timer_base = `TIMER_BASE;

	logic upstream;
	logic reset;
	apb_req_t req;
	apb_resp_t resp;
	logic timer_irq;

	step_t steps[$];
	// Expected scratch contents
	logic [`APB_DATA_WIDTH-1:0] model [`SCRATCH_WORDS];
	logic [31:0] lfsr;

	apb_subsystem UUT (
		.upstream(upstream),
		.reset(reset),
		.req(req),
		.resp(resp),
		.timer_irq(timer_irq)
	);

	always #2 upstream = ~upstream;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] bits;
		logic fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	// Strobed bytes come from the new data
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_data,
		input logic [31:0] new_data, input logic [3:0] strb);
		logic [31:0] merged;
		merged = old_data;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				merged[8*b +: 8] = new_data[8*b +: 8];
		return merged;
	endfunction

	function automatic step_t make_step(input logic write, input logic [15:0] addr,
		input logic [31:0] wdata, input logic [3:0] strb, input logic [31:0] exp_rdata,
		input logic exp_err);
		step_t s;
		s.write = write;
		s.addr = addr;
		s.wdata = wdata;
		s.strb = strb;
		s.exp_rdata = exp_rdata;
		s.exp_err = exp_err;
		return s;
	endfunction

	task automatic abort_run(input string why);
		$display("Testbench failed");
		$display("%s", why);
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("Testbench failed");
		$display("mismatch %s expected %h actual %h", name, exp, act);
		$fatal(1);
	endtask

	// Read data compared only on reads
	task automatic check_resp(input string name, input apb_resp_t exp, input apb_resp_t act,
		input logic is_read);
		if (is_read && act.prdata !== exp.prdata)
			report_mismatch({name, ".prdata"}, exp.prdata, act.prdata);
		if (act.pslverr !== exp.pslverr)
			report_mismatch({name, ".pslverr"}, exp.pslverr, act.pslverr);
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_mismatch(name, exp, act);
	endtask

	//////////////////////////////////////////////////////////////////////
	// APB driver
	//////////////////////////////////////////////////////////////////////

	// Starts and ends on a falling edge, request left held for back-to-back
	task automatic apb_access(input logic write, input logic [15:0] addr,
		input logic [31:0] wdata, input logic [3:0] strb, output apb_resp_t got);
		int waited;
		req.paddr = addr;
		req.psel = 1'b1;
		req.penable = 1'b0;
		req.pwrite = write;
		req.pwdata = wdata;
		req.pstrb = strb;
		req.pprot = '0;
		@(negedge upstream);
		// A late pready here means the completer saw a second access phase
		if (resp.pready)
			abort_run("pready seen in the setup cycle of a new transfer");
		// Access phase
		req.penable = 1'b1;
		waited = 0;
		@(negedge upstream);
		while (!resp.pready) begin
			if (waited == 20)
				abort_run("no pready within 20 cycles of the access phase");
			waited++;
			@(negedge upstream);
		end
		got = resp;
	endtask

	task automatic bus_idle();
		req.psel = 1'b0;
		req.penable = 1'b0;
		@(negedge upstream);
	endtask

	task automatic run_step(input step_t s);
		apb_resp_t got;
		apb_resp_t exp;
		apb_access(s.write, s.addr, s.wdata, s.strb, got);
		exp.pready = 1'b1;
		exp.prdata = s.exp_rdata;
		exp.pslverr = s.exp_err;
		check_resp($sformatf("resp[%h]", s.addr), exp, got, !s.write);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		int waited;
		int idx;
		logic [31:0] data;
		logic [3:0] strb;
		logic [2:0] alias_bits;

		upstream = 1'b0;
		reset = 1'b1;
		req = '0;
		lfsr = 32'h634;
		repeat (8) @(negedge upstream);
		reset = 1'b0;
		@(negedge upstream);
		check_level("timer_irq", 1'b0, timer_irq);

		// Byte strobes on scratch word 2, merged 11BB33DD
		steps.push_back(make_step(1, 16'h0008, 32'h11223344, 4'hF, 32'h0, 0));
		steps.push_back(make_step(1, 16'h0008, 32'hAABBCCDD, 4'h5, 32'h0, 0));
		steps.push_back(make_step(0, 16'h0008, 32'h0, 4'h0, 32'h11BB33DD, 0));
		// Aliased index, same word
		steps.push_back(make_step(0, 16'h0028, 32'h0, 4'h0, 32'h11BB33DD, 0));
		// Unmapped region
		steps.push_back(make_step(0, 16'h0200, 32'h0, 4'h0, 32'h0, 1));
		steps.push_back(make_step(1, 16'h0200, 32'h5A5A5A5A, 4'hF, 32'h0, 1));
		steps.push_back(make_step(0, 16'h0008, 32'h0, 4'h0, 32'h11BB33DD, 0));
		// Timer registers with the counter stopped
		steps.push_back(make_step(1, 16'h0104, 32'h12345678, 4'hF, 32'h0, 0));
		steps.push_back(make_step(0, 16'h0104, 32'h0, 4'h0, 32'h12345678, 0));
		steps.push_back(make_step(1, 16'h0108, 32'hCAFE0042, 4'hF, 32'h0, 0));
		steps.push_back(make_step(0, 16'h0108, 32'h0, 4'h0, 32'hCAFE0042, 0));
		steps.push_back(make_step(0, 16'h0100, 32'h0, 4'h0, 32'h0, 0));
		steps.push_back(make_step(0, 16'h010C, 32'h0, 4'h0, 32'h0, 0));
		// Offset past the four timer registers
		steps.push_back(make_step(0, 16'h0110, 32'h0, 4'h0, 32'h0, 1));
		steps.push_back(make_step(1, 16'h0110, 32'hFFFFFFFF, 4'hF, 32'h0, 1));
		steps.push_back(make_step(0, 16'h0108, 32'h0, 4'h0, 32'hCAFE0042, 0));

		foreach (steps[i])
			run_step(steps[i]);
		bus_idle();

		// Random scratch traffic, all back to back
		for (int i = 0; i < `SCRATCH_WORDS; i++) begin
			data = random_bits(32);
			model[i] = data;
			run_step(make_step(1, 16'(i * 4), data, 4'hF, 32'h0, 0));
		end
		for (int i = 0; i < 24; i++) begin
			idx = random_bits(3);
			alias_bits = random_bits(3);
			strb = random_bits(4);
			data = random_bits(32);
			model[idx] = merge_bytes(model[idx], data, strb);
			run_step(make_step(1, {8'h00, alias_bits, 3'(idx), 2'b00}, data, strb, 32'h0, 0));
		end
		// Read back in a shuffled order
		for (int i = 0; i < `SCRATCH_WORDS; i++) begin
			idx = (i * 5 + 3) % `SCRATCH_WORDS;
			run_step(make_step(0, 16'(idx * 4), 32'h0, 4'h0, model[idx], 0));
		end
		bus_idle();

		// Timer match at count 20
		run_step(make_step(1, timer_base | TIMER_COUNT, 32'd0, 4'hF, 32'h0, 0));
		run_step(make_step(1, timer_base | TIMER_COMPARE, 32'd20, 4'hF, 32'h0, 0));
		run_step(make_step(1, timer_base | TIMER_CTRL, 32'd1, 4'hF, 32'h0, 0));
		bus_idle();
		waited = 0;
		while (!timer_irq) begin
			if (waited == 100)
				abort_run("timer_irq did not rise within 100 cycles");
			waited++;
			@(negedge upstream);
		end
		run_step(make_step(0, timer_base | TIMER_STATUS, 32'h0, 4'h0, 32'h1, 0));
		// Stop the counter, then clear the sticky flag
		run_step(make_step(1, timer_base | TIMER_CTRL, 32'd0, 4'hF, 32'h0, 0));
		run_step(make_step(1, timer_base | TIMER_STATUS, 32'd1, 4'hF, 32'h0, 0));
		check_level("timer_irq", 1'b0, timer_irq);
		run_step(make_step(0, timer_base | TIMER_STATUS, 32'h0, 4'h0, 32'h0, 0));
		bus_idle();

		$display("Testbench passed");
		$finish;
	end

endmodule
